// File: dv/klxLoaderTb.sv
// KL10 loader testbench
module klxLoaderTb;
  timeunit 1ns;
  timeprecision 1ps;

  import klxFormatPkg::*;
  import ramPkg::*;

  localparam logic [31:0] SEED = 32'h934ceda8;
  // Longest line replay plus the widest random gap, per character
  localparam int CYCLES_PER_CHAR = 40;
  // Reset and store reads
  localparam int TIMEOUT_MARGIN = 1000;

  logic      clk;
  logic      arstN;
  logic      charValid;
  logic [7:0] charData;
  logic      creditReturn;
  logic      lineDone;
  logic      lineError;
  cramAddrT  cramRdAddr;
  cramWordT  cramRdData;
  dramAddrT  dramRdAddr;
  dramEntryT dramRdData;

  // Run bookkeeping
  int sentCount = 0;
  int returnCount = 0;
  int doneCount = 0;
  int lineErrCount = 0;
  int failCount = 0;
  int cycleCount = 0;
  int maxGap = 2;

  // Line under construction
  loadWordT   fieldQ [$];
  logic [7:0] txQ [$];
  cramWordT   savedLoc [2];
  cramWordT   zeroLoc;

  klxLoader klxLoader_i (
    .clk          (clk),
    .arstN        (arstN),
    .charValid    (charValid),
    .charData     (charData),
    .creditReturn (creditReturn),
    .lineDone     (lineDone),
    .lineError    (lineError),
    .cramRdAddr   (cramRdAddr),
    .cramRdData   (cramRdData),
    .dramRdAddr   (dramRdAddr),
    .dramRdData   (dramRdData)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Credits come back at the clock edge of the pop
  always @(posedge clk) begin
    if (creditReturn === 1'b1) begin
      returnCount++;
      // A credit only comes back for a character already sent
      checkEq("creditReturn", returnCount > sentCount, 0);
    end
    if (lineDone === 1'b1) doneCount++;
    if (lineDone === 1'b1 && lineError === 1'b1) lineErrCount++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and end of run

  task automatic checkEq(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      failCount++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finishRun();
    $display("Run done: %0d errors, %0d lines, %0d characters sent",
             failCount, doneCount, sentCount);
    if (failCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // Limit grows with every character sent
  initial begin
    while (cycleCount <= sentCount * CYCLES_PER_CHAR + TIMEOUT_MARGIN) begin
      @(posedge clk);
      cycleCount++;
    end
    failCount++;
    $display("Timeout: run exceeded %0d cycles", cycleCount);
    finishRun();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Encoder

  // Six bits per character, leading zero fields dropped, zero is empty
  task automatic putWord(input loadWordT w);
    int       n;
    loadWordT part;
    n = 0;
    if (w != '0) n = (w < 16'd64) ? 1 : (w < 16'd4096) ? 2 : 3;
    for (int i = n - 1; i >= 0; i--) begin
      part = w >> (FIELD_BITS * i);
      txQ.push_back({2'b01, part[5:0]});
    end
  endtask

  task automatic startRecord(input loadWordT count, input loadWordT addr);
    fieldQ.delete();
    fieldQ.push_back(count);
    fieldQ.push_back(addr);
  endtask

  task automatic addRandomWords(input int n);
    repeat (n) fieldQ.push_back(loadWordT'($urandom));
  endtask

  // Type, space, fields, then the negated sum
  task automatic buildRecord(input logic [7:0] kindChar, input bit badSum);
    loadWordT sum;
    sum = '0;
    txQ.delete();
    txQ.push_back(kindChar);
    txQ.push_back(CHAR_SPACE);
    foreach (fieldQ[i]) begin
      putWord(fieldQ[i]);
      txQ.push_back(CHAR_COMMA);
      sum = sum + fieldQ[i];
    end
    sum = -sum;
    if (badSum) sum = sum ^ 16'h0001;
    putWord(sum);
    txQ.push_back(CHAR_CR);
    txQ.push_back(CHAR_NEWLINE);
  endtask

  task automatic buildText(input string s);
    txQ.delete();
    for (int i = 0; i < s.len(); i++) txQ.push_back(s[i]);
    txQ.push_back(CHAR_CR);
    txQ.push_back(CHAR_NEWLINE);
  endtask

  // Expected images straight from the load format
  function automatic cramWordT cramImage(input int first);
    cramWordT img;
    loadWordT special;
    special = fieldQ[first + 5];
    img = '0;
    img[79:64] = fieldQ[first];
    img[63:48] = fieldQ[first + 1];
    img[47:32] = fieldQ[first + 2];
    img[31:16] = fieldQ[first + 3];
    img[15:0] = fieldQ[first + 4];
    img[85:80] = special[5:0];
    return img;
  endfunction

  function automatic dramEntryT dramImage(input loadWordT own, input loadWordT odd,
                                          input loadWordT common);
    dramEntryT entry;
    entry = {own[13:8], own[5], common[3:0], odd[3], own[2:0]};
    return entry;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Driver and store access

  // One character per falling edge, only with a credit in hand
  task automatic sendChar(input logic [7:0] c);
    int unsigned gap;
    gap = $urandom_range(maxGap, 0);
    @(negedge clk);
    charValid = 1'b0;
    while (gap > 0 || sentCount - returnCount >= CHAR_FIFO_DEPTH) begin
      if (gap > 0) gap--;
      @(negedge clk);
    end
    charValid = 1'b1;
    charData = c;
    sentCount++;
  endtask

  task automatic sendQueued();
    foreach (txQ[i]) sendChar(txQ[i]);
    @(negedge clk);
    charValid = 1'b0;
  endtask

  task automatic waitDone(input int target);
    while (doneCount < target) @(negedge clk);
  endtask

  task automatic lineAndCheck(input int expErr);
    int doneBefore;
    int errBefore;
    doneBefore = doneCount;
    errBefore = lineErrCount;
    sendQueued();
    waitDone(doneBefore + 1);
    checkEq("lineError", lineErrCount - errBefore, expErr);
  endtask

  // Registered read, data one cycle after the address
  task automatic checkCramAt(input cramAddrT addr, input cramWordT exp);
    @(negedge clk);
    cramRdAddr = addr;
    @(negedge clk);
    checkEq("cramRdData", cramRdData, exp);
  endtask

  task automatic checkDramAt(input dramAddrT addr, input dramEntryT exp);
    @(negedge clk);
    dramRdAddr = addr;
    @(negedge clk);
    checkEq("dramRdData", dramRdData, exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic cramLoadTest();
    startRecord(16'd12, 16'o136);
    addRandomWords(12);
    savedLoc[0] = cramImage(2);
    savedLoc[1] = cramImage(8);
    buildRecord(REC_CRAM, 1'b0);
    lineAndCheck(0);
    checkCramAt(11'o136, savedLoc[0]);
    checkCramAt(11'o137, savedLoc[1]);
  endtask

  task automatic dramLoadTest();
    dramEntryT expEven;
    dramEntryT expOdd;
    startRecord(16'd3, 16'o254);
    addRandomWords(3);
    // Odd word supplies j7 to both entries
    expEven = dramImage(fieldQ[2], fieldQ[3], fieldQ[4]);
    expOdd = dramImage(fieldQ[3], fieldQ[3], fieldQ[4]);
    buildRecord(REC_DRAM, 1'b0);
    lineAndCheck(0);
    checkDramAt(9'o254, expEven);
    checkDramAt(9'o255, expOdd);
  endtask

  task automatic badLineTest();
    startRecord(16'd6, 16'o136);
    addRandomWords(6);
    buildRecord(REC_CRAM, 1'b1);
    lineAndCheck(1);
    checkCramAt(11'o136, savedLoc[0]);
    // Good checksum but count disagrees with the data
    startRecord(16'd12, 16'o137);
    addRandomWords(6);
    buildRecord(REC_CRAM, 1'b0);
    lineAndCheck(1);
    checkCramAt(11'o137, savedLoc[1]);
  endtask

  task automatic continuationTest();
    cramWordT first;
    cramWordT second;
    startRecord(16'd6, 16'h200);
    addRandomWords(6);
    first = cramImage(2);
    buildRecord(REC_CRAM, 1'b0);
    lineAndCheck(0);
    startRecord(16'd6, 16'h0);
    addRandomWords(6);
    second = cramImage(2);
    buildRecord(REC_CRAM, 1'b0);
    lineAndCheck(0);
    checkCramAt(11'h200, first);
    checkCramAt(11'h201, second);
    // Two empty fields make an end line
    buildText("C ,");
    lineAndCheck(0);
    startRecord(16'd6, 16'h0);
    addRandomWords(6);
    zeroLoc = cramImage(2);
    buildRecord(REC_CRAM, 1'b0);
    lineAndCheck(0);
    checkCramAt(11'h0, zeroLoc);
  endtask

  task automatic skippedLineTest();
    buildText("; KL10 microcode load file");
    lineAndCheck(0);
    startRecord(16'd3, 16'h0);
    fieldQ.push_back(16'd1);
    fieldQ.push_back(16'd2);
    fieldQ.push_back(16'd3);
    buildRecord(REC_ZERO, 1'b0);
    lineAndCheck(0);
    checkCramAt(11'h0, zeroLoc);
    buildText("X 1,2,3");
    lineAndCheck(1);
  endtask

  task automatic creditFlowTest();
    dramEntryT dramExp [6];
    cramWordT  cramExp [5];
    int        doneBefore;
    int        errBefore;
    maxGap = 6;
    doneBefore = doneCount;
    errBefore = lineErrCount;
    startRecord(16'd9, 16'h40);
    addRandomWords(9);
    for (int p = 0; p < 3; p++) begin
      dramExp[2 * p] = dramImage(fieldQ[2 + 3 * p], fieldQ[3 + 3 * p], fieldQ[4 + 3 * p]);
      dramExp[2 * p + 1] = dramImage(fieldQ[3 + 3 * p], fieldQ[3 + 3 * p], fieldQ[4 + 3 * p]);
    end
    buildRecord(REC_DRAM, 1'b0);
    sendQueued();
    // Longest C line follows while the D line replays
    startRecord(16'd30, 16'h300);
    addRandomWords(30);
    for (int l = 0; l < 5; l++) cramExp[l] = cramImage(2 + 6 * l);
    buildRecord(REC_CRAM, 1'b0);
    sendQueued();
    waitDone(doneBefore + 2);
    checkEq("lineError", lineErrCount - errBefore, 0);
    for (int e = 0; e < 6; e++) checkDramAt(dramAddrT'(9'h40 + e), dramExp[e]);
    for (int l = 0; l < 5; l++) checkCramAt(cramAddrT'(11'h300 + l), cramExp[l]);
    checkEq("creditReturn", returnCount, sentCount);
    maxGap = 2;
  endtask

  initial begin
    void'($urandom(SEED));
    arstN = 1'b0;
    charValid = 1'b0;
    charData = '0;
    cramRdAddr = '0;
    dramRdAddr = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    cramLoadTest();
    dramLoadTest();
    badLineTest();
    continuationTest();
    skippedLineTest();
    creditFlowTest();
    finishRun();
  end

endmodule

// File: filelist.f
src/klxFormatPkg.sv
src/ramPkg.sv
src/charFifo.sv
src/asciiWordDecoder.sv
src/recordParser.sv
src/cramWriter.sv
src/dramWriter.sv
src/ramStore.sv
src/klxLoader.sv
dv/klxLoaderTb.sv

// File: src/asciiWordDecoder.sv
// ASCIIized word decoder
module asciiWordDecoder (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   fifoValid,
  input  logic [7:0]             fifoChar,
  output logic                   fifoPop,
  input  logic                   wordReady,
  output logic                   typeValid,
  output klxFormatPkg::recKindT  recKind,
  output logic                   wordValid,
  output klxFormatPkg::loadWordT word,
  output logic                   lineEnd
);
  import klxFormatPkg::*;

  logic     lineStart;
  logic     expectSpace;
  logic     skipLine;
  logic     pendingEnd;
  loadWordT acc;
  recKindT  charKind;
  logic     popNow;
  logic     isCr;
  logic     isNewline;
  logic     isComma;
  logic     startChar;
  logic     endChar;
  logic     fieldChar;
  logic     skipSpace;
  logic     closeField;
  logic     addChar;

  function automatic recKindT classify(logic [7:0] ch);
    case (ch)
      REC_CRAM: return KIND_CRAM;
      REC_DRAM: return KIND_DRAM;
      REC_ZERO, REC_COMMENT: return KIND_IGNORED;
      default: return KIND_UNKNOWN;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Character classification

  // Hold off while a line end is on its way to the parser
  assign popNow = fifoValid && wordReady && !pendingEnd && !lineEnd;
  assign fifoPop = popNow;

  assign isCr = (fifoChar == CHAR_CR);
  assign isNewline = (fifoChar == CHAR_NEWLINE);
  assign isComma = (fifoChar == CHAR_COMMA);
  assign charKind = classify(fifoChar);

  // First printable character of a line names the record
  assign startChar = popNow && !isCr && lineStart && !isNewline;
  assign endChar = popNow && !isCr && !lineStart && isNewline;
  // Skipped lines only look for their newline
  assign fieldChar = popNow && !isCr && !lineStart && !isNewline && !skipLine;
  assign skipSpace = fieldChar && expectSpace && (fifoChar == CHAR_SPACE);
  // Newline flushes the last field
  assign closeField = (endChar && !skipLine) || (fieldChar && isComma);
  assign addChar = fieldChar && !isComma && !skipSpace;

  ////////////////////////////////////////////////////////////////////////////
  // Line state and output pulses

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lineStart <= 1'b1;
      expectSpace <= 1'b0;
      skipLine <= 1'b0;
      pendingEnd <= 1'b0;
      typeValid <= 1'b0;
      wordValid <= 1'b0;
      lineEnd <= 1'b0;
    end else begin
      typeValid <= startChar;
      wordValid <= closeField;
      // Line end follows the flushed word by one cycle
      pendingEnd <= endChar;
      lineEnd <= pendingEnd;
      if (startChar) begin
        lineStart <= 1'b0;
        skipLine <= !(charKind == KIND_CRAM || charKind == KIND_DRAM);
      end
      if (endChar) begin
        lineStart <= 1'b1;
      end
      // Only the character right after the type may be a space
      if (popNow && !isCr) begin
        expectSpace <= startChar;
      end
    end
  end

  // Field accumulator shifts six bits per character
  always_ff @(posedge clk) begin
    if (startChar) begin
      recKind <= charKind;
    end
    if (closeField) begin
      word <= acc;
    end
    if (startChar || closeField) begin
      acc <= '0;
    end else if (addChar) begin
      acc <= {acc[WORD_BITS-FIELD_BITS-1:0], fifoChar[FIELD_BITS-1:0]};
    end
  end

endmodule

// File: src/charFifo.sv
// Character input queue
module charFifo (
  input  logic       clk,
  input  logic       arstN,
  input  logic       charValid,
  input  logic [7:0] charData,
  input  logic       fifoPop,
  output logic       fifoValid,
  output logic [7:0] fifoChar,
  output logic       creditReturn
);
  import klxFormatPkg::*;

  localparam int PTR_BITS = $clog2(CHAR_FIFO_DEPTH);
  localparam int CNT_BITS = $clog2(CHAR_FIFO_DEPTH + 1);

  logic [7:0]          slots [CHAR_FIFO_DEPTH];
  logic [PTR_BITS-1:0] wrPtr;
  logic [PTR_BITS-1:0] rdPtr;
  logic [CNT_BITS-1:0] fill;
  logic                popNow;

  // Circular wrap that also works for depths other than a power of two
  function automatic logic [PTR_BITS-1:0] nextPtr(logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(CHAR_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign fifoValid = (fill != '0);
  assign fifoChar = slots[rdPtr];
  assign popNow = fifoPop && fifoValid;
  // Each pop hands one credit back to the sender
  assign creditReturn = popNow;

  always_ff @(posedge clk) begin
    if (charValid) begin
      slots[wrPtr] <= charData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill <= '0;
    end else begin
      if (charValid) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (popNow) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({charValid, popNow})
        2'b10: fill <= fill + 1'b1;
        2'b01: fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // A sender that keeps its credit count never finds the queue full
  pushNotFull: assert property (@(posedge clk) disable iff (!arstN)
    charValid |-> fill != CNT_BITS'(CHAR_FIFO_DEPTH))
    else $error("charFifo push while full");

endmodule

// File: src/cramWriter.sv
// Control RAM word assembler
module cramWriter (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   dataValid,
  input  klxFormatPkg::loadWordT dataWord,
  input  klxFormatPkg::loadWordT dataAddr,
  input  logic                   dataFirst,
  output logic                   cramWe,
  output ramPkg::cramAddrT       cramWrAddr,
  output ramPkg::cramWordT       cramWrData
);
  import klxFormatPkg::*;
  import ramPkg::*;

  logic [2:0] slot;
  logic [2:0] curSlot;
  logic       locDone;
  cramAddrT   locAddr;

  // First word of a line always starts a new location
  assign curSlot = dataFirst ? '0 : slot;
  assign locDone = dataValid && (curSlot == 3'(CRAM_WORDS_PER_LOC - 1));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      slot <= '0;
      cramWe <= 1'b0;
    end else begin
      cramWe <= locDone;
      if (dataValid) begin
        slot <= locDone ? '0 : curSlot + 1'b1;
      end
    end
  end

  // Words fill the output word in load file order
  always_ff @(posedge clk) begin
    if (dataValid && dataFirst) begin
      locAddr <= cramAddrT'(dataAddr);
    end else if (locDone) begin
      locAddr <= locAddr + 1'b1;
    end
    if (locDone) begin
      cramWrAddr <= locAddr;
    end
    if (dataValid) begin
      case (curSlot)
        3'd0: cramWrData[79:64] <= dataWord;
        3'd1: cramWrData[63:48] <= dataWord;
        3'd2: cramWrData[47:32] <= dataWord;
        3'd3: cramWrData[31:16] <= dataWord;
        3'd4: cramWrData[15:0] <= dataWord;
        // Special field CALL and DISP
        3'd5: cramWrData[85:80] <= dataWord[5:0];
        default: ;
      endcase
    end
  end

endmodule

// File: src/dramWriter.sv
// Dispatch RAM pair writer
module dramWriter (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   dataValid,
  input  klxFormatPkg::loadWordT dataWord,
  input  klxFormatPkg::loadWordT dataAddr,
  input  logic                   dataFirst,
  output logic                   dramWe,
  output ramPkg::dramAddrT       dramWrAddr,
  output ramPkg::dramEntryT      dramWrData
);
  import klxFormatPkg::*;
  import ramPkg::*;

  logic [1:0] slot;
  logic [1:0] curSlot;
  logic       pairDone;
  logic       oddPending;
  dramAddrT   pairAddr;
  loadWordT   eWord;
  loadWordT   oWord;
  dramEntryT  oddEntry;

  // Word layout from the WDRAM format
  // A in 13 to 11, B in 10 to 8, parity in 5 and J8 to J10 in 2 to 0
  function automatic dramEntryT splitEntry(loadWordT own, loadWordT odd, loadWordT common);
    dramEntryT entry;
    entry.dispA = own[13:11];
    entry.dispB = own[10:8];
    entry.parity = own[5];
    entry.jCommon = common[3:0];
    // J7 is common but only carried by the odd word
    entry.j7 = odd[3];
    entry.jLow = own[2:0];
    return entry;
  endfunction

  assign curSlot = dataFirst ? '0 : slot;
  assign pairDone = dataValid && (curSlot == 2'(DRAM_WORDS_PER_PAIR - 1));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      slot <= '0;
      dramWe <= 1'b0;
      oddPending <= 1'b0;
    end else begin
      // Even entry then odd entry on back to back cycles
      dramWe <= pairDone || oddPending;
      oddPending <= pairDone;
      if (dataValid) begin
        slot <= pairDone ? '0 : curSlot + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dataValid && dataFirst) begin
      pairAddr <= dramAddrT'(dataAddr);
    end else if (pairDone) begin
      pairAddr <= pairAddr + dramAddrT'(2);
    end
    if (dataValid && curSlot == 2'd0) begin
      eWord <= dataWord;
    end
    if (dataValid && curSlot == 2'd1) begin
      oWord <= dataWord;
    end
    // Both entries are built at once so the next pair may refill E and O
    if (pairDone) begin
      dramWrAddr <= pairAddr;
      dramWrData <= splitEntry(eWord, oWord, dataWord);
      oddEntry <= splitEntry(oWord, oWord, dataWord);
    end else if (oddPending) begin
      dramWrAddr <= dramWrAddr + 1'b1;
      dramWrData <= oddEntry;
    end
  end

  // Pairs start on an even address through continuation as well
  pairAligned: assert property (@(posedge clk) disable iff (!arstN)
    (dataValid && dataFirst) |-> !dataAddr[0])
    else $error("dramWriter odd pair address");

endmodule

// File: src/klxFormatPkg.sv
// Load file format definitions
package klxFormatPkg;

  // Each ASCIIized character carries six payload bits
  localparam int FIELD_BITS = 6;
  // Words in the load file are PDP-11 sized
  localparam int WORD_BITS = 16;

  // Credits the sender holds after reset
  localparam int CHAR_FIFO_DEPTH = 4;

  // Five C locations or ten D pairs per line at most
  localparam int LINE_MAX_WORDS = 30;
  localparam int CRAM_WORDS_PER_LOC = 6;
  localparam int DRAM_WORDS_PER_PAIR = 3;

  // Separators
  localparam logic [7:0] CHAR_COMMA = 8'h2c;
  localparam logic [7:0] CHAR_NEWLINE = 8'h0a;
  localparam logic [7:0] CHAR_CR = 8'h0d;
  localparam logic [7:0] CHAR_SPACE = 8'h20;

  // Record type characters in the first column
  localparam logic [7:0] REC_CRAM = 8'h43;
  localparam logic [7:0] REC_DRAM = 8'h44;
  localparam logic [7:0] REC_ZERO = 8'h5a;
  localparam logic [7:0] REC_COMMENT = 8'h3b;

  typedef logic [WORD_BITS-1:0] loadWordT;

  // Z records and comments both land in KIND_IGNORED
  typedef enum logic [2:0] {
    KIND_NONE,
    KIND_CRAM,
    KIND_DRAM,
    KIND_IGNORED,
    KIND_UNKNOWN
  } recKindT;

endpackage

// File: src/klxLoader.sv
// KL10 microcode loader top
module klxLoader (
  input  logic              clk,
  input  logic              arstN,
  input  logic              charValid,
  input  logic [7:0]        charData,
  output logic              creditReturn,
  output logic              lineDone,
  output logic              lineError,
  input  ramPkg::cramAddrT  cramRdAddr,
  output ramPkg::cramWordT  cramRdData,
  input  ramPkg::dramAddrT  dramRdAddr,
  output ramPkg::dramEntryT dramRdData
);
  import klxFormatPkg::*;
  import ramPkg::*;

  // Queue to decoder
  logic       fifoValid;
  logic [7:0] fifoChar;
  logic       fifoPop;

  // Decoder to parser
  logic       wordReady;
  logic       typeValid;
  recKindT    recKind;
  logic       wordValid;
  loadWordT   word;
  logic       lineEnd;

  // Parser to writers
  logic       cramDataValid;
  logic       dramDataValid;
  loadWordT   dataWord;
  loadWordT   dataAddr;
  logic       dataFirst;

  // Writers to stores
  logic       cramWe;
  cramAddrT   cramWrAddr;
  cramWordT   cramWrData;
  logic       dramWe;
  dramAddrT   dramWrAddr;
  dramEntryT  dramWrData;

  ////////////////////////////////////////////////////////////////////////////
  // Front end

  charFifo charFifo_i (
    .clk          (clk),
    .arstN        (arstN),
    .charValid    (charValid),
    .charData     (charData),
    .fifoPop      (fifoPop),
    .fifoValid    (fifoValid),
    .fifoChar     (fifoChar),
    .creditReturn (creditReturn)
  );

  asciiWordDecoder asciiWordDecoder_i (
    .clk       (clk),
    .arstN     (arstN),
    .fifoValid (fifoValid),
    .fifoChar  (fifoChar),
    .fifoPop   (fifoPop),
    .wordReady (wordReady),
    .typeValid (typeValid),
    .recKind   (recKind),
    .wordValid (wordValid),
    .word      (word),
    .lineEnd   (lineEnd)
  );

  recordParser recordParser_i (
    .clk           (clk),
    .arstN         (arstN),
    .typeValid     (typeValid),
    .recKind       (recKind),
    .wordValid     (wordValid),
    .word          (word),
    .lineEnd       (lineEnd),
    .wordReady     (wordReady),
    .cramDataValid (cramDataValid),
    .dramDataValid (dramDataValid),
    .dataWord      (dataWord),
    .dataAddr      (dataAddr),
    .dataFirst     (dataFirst),
    .lineDone      (lineDone),
    .lineError     (lineError)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Writers and stores

  cramWriter cramWriter_i (
    .clk        (clk),
    .arstN      (arstN),
    .dataValid  (cramDataValid),
    .dataWord   (dataWord),
    .dataAddr   (dataAddr),
    .dataFirst  (dataFirst),
    .cramWe     (cramWe),
    .cramWrAddr (cramWrAddr),
    .cramWrData (cramWrData)
  );

  dramWriter dramWriter_i (
    .clk        (clk),
    .arstN      (arstN),
    .dataValid  (dramDataValid),
    .dataWord   (dataWord),
    .dataAddr   (dataAddr),
    .dataFirst  (dataFirst),
    .dramWe     (dramWe),
    .dramWrAddr (dramWrAddr),
    .dramWrData (dramWrData)
  );

  ramStore #(.entryT(cramWordT), .DEPTH(CRAM_DEPTH)) cramStore_i (
    .clk    (clk),
    .we     (cramWe),
    .wrAddr (cramWrAddr),
    .wrData (cramWrData),
    .rdAddr (cramRdAddr),
    .rdData (cramRdData)
  );

  ramStore #(.entryT(dramEntryT), .DEPTH(DRAM_DEPTH)) dramStore_i (
    .clk    (clk),
    .we     (dramWe),
    .wrAddr (dramWrAddr),
    .wrData (dramWrData),
    .rdAddr (dramRdAddr),
    .rdData (dramRdData)
  );

endmodule

// File: src/ramPkg.sv
// Control store and dispatch RAM types
package ramPkg;

  // Control RAM
  localparam int CRAM_DEPTH = 2048;
  localparam int CRAM_ADDR_BITS = $clog2(CRAM_DEPTH);
  // 80 data bits plus the six bit CALL and DISP special field
  localparam int CRAM_WORD_BITS = 86;

  typedef logic [CRAM_ADDR_BITS-1:0] cramAddrT;
  typedef logic [CRAM_WORD_BITS-1:0] cramWordT;

  // Dispatch RAM
  localparam int DRAM_DEPTH = 512;
  localparam int DRAM_ADDR_BITS = $clog2(DRAM_DEPTH);

  typedef logic [DRAM_ADDR_BITS-1:0] dramAddrT;

  // One dispatch entry
  // J5 and J6 do not exist in the hardware
  typedef struct packed {
    logic [2:0] dispA;
    logic [2:0] dispB;
    logic       parity;
    // J1 to J4 shared by an even and odd pair
    logic [3:0] jCommon;
    // Also shared and written from the odd word
    logic       j7;
    // J8 to J10
    logic [2:0] jLow;
  } dramEntryT;

endpackage

// File: src/ramStore.sv
// Single port write, single port read memory
module ramStore #(
  parameter type entryT = logic,
  parameter int  DEPTH = 2
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] wrAddr,
  input  entryT                    wrData,
  input  logic [$clog2(DEPTH)-1:0] rdAddr,
  output entryT                    rdData
);

  entryT mem [DEPTH];

  // Read data is registered
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wrAddr] <= wrData;
    end
    rdData <= mem[rdAddr];
  end

endmodule

// File: src/recordParser.sv
// Load line parser and checker
module recordParser (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   typeValid,
  input  klxFormatPkg::recKindT  recKind,
  input  logic                   wordValid,
  input  klxFormatPkg::loadWordT word,
  input  logic                   lineEnd,
  output logic                   wordReady,
  output logic                   cramDataValid,
  output logic                   dramDataValid,
  output klxFormatPkg::loadWordT dataWord,
  output klxFormatPkg::loadWordT dataAddr,
  output logic                   dataFirst,
  output logic                   lineDone,
  output logic                   lineError
);
  import klxFormatPkg::*;

  // Data words and the checksum word
  localparam int BUF_WORDS = LINE_MAX_WORDS + 1;
  localparam int BUF_BITS = $clog2(BUF_WORDS);
  // Count and address come ahead of the buffered words
  localparam int IDX_BITS = $clog2(BUF_WORDS + 3);

  typedef enum logic [2:0] {
    ST_INIT,
    ST_COLLECT,
    ST_CHECK,
    ST_REPLAY,
    ST_DRAIN
  } stateT;

  stateT               state;
  recKindT             kind;
  logic [IDX_BITS-1:0] wordIdx;
  logic                overflow;
  loadWordT            sum;
  loadWordT            wordCount;
  loadWordT            rawAddr;
  loadWordT            lineAddr;
  loadWordT            nextCram;
  loadWordT            nextDram;
  loadWordT            dataBuf [BUF_WORDS];
  logic [BUF_BITS-1:0] replayIdx;
  logic [BUF_BITS-1:0] replayLast;
  logic [2:0]          groupCnt;
  logic                drainCnt;
  logic [IDX_BITS-1:0] dataCount;
  logic                isData;
  logic                endLine;
  logic                lineGood;
  logic                lastInGroup;
  loadWordT            baseAddr;

  ////////////////////////////////////////////////////////////////////////////
  // Line checks

  assign dataCount = wordIdx - IDX_BITS'(3);
  assign isData = (kind == KIND_CRAM) || (kind == KIND_DRAM);
  // Zero count and zero address close a section
  assign endLine = (wordIdx >= IDX_BITS'(2)) && (wordCount == '0) && (rawAddr == '0);
  // Negated checksum brings the sum of all words to zero
  assign lineGood = !overflow && (wordIdx >= IDX_BITS'(3)) && (sum == '0) &&
                    (wordCount == loadWordT'(dataCount));
  // Zero address continues the previous line of the same kind
  assign baseAddr = (rawAddr != '0) ? rawAddr : (kind == KIND_DRAM) ? nextDram : nextCram;
  assign lastInGroup = (kind == KIND_DRAM) ? (groupCnt == 3'(DRAM_WORDS_PER_PAIR - 1)) :
                                             (groupCnt == 3'(CRAM_WORDS_PER_LOC - 1));

  // Replay outputs
  assign wordReady = (state == ST_COLLECT);
  assign cramDataValid = (state == ST_REPLAY) && (kind == KIND_CRAM);
  assign dramDataValid = (state == ST_REPLAY) && (kind == KIND_DRAM);
  assign dataWord = dataBuf[replayIdx];
  assign dataAddr = lineAddr;
  assign dataFirst = (replayIdx == '0);

  // Count, address and buffered words
  always_ff @(posedge clk) begin
    if (wordReady && wordValid) begin
      if (wordIdx == IDX_BITS'(0)) begin
        wordCount <= word;
      end else if (wordIdx == IDX_BITS'(1)) begin
        rawAddr <= word;
      end else if (wordIdx < IDX_BITS'(BUF_WORDS + 2)) begin
        dataBuf[BUF_BITS'(wordIdx - IDX_BITS'(2))] <= word;
      end
    end
    if (state == ST_CHECK) begin
      lineAddr <= baseAddr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Line FSM

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= ST_INIT;
      kind <= KIND_NONE;
      wordIdx <= '0;
      overflow <= 1'b0;
      sum <= '0;
      nextCram <= '0;
      nextDram <= '0;
      replayIdx <= '0;
      replayLast <= '0;
      groupCnt <= '0;
      drainCnt <= 1'b0;
      lineDone <= 1'b0;
      lineError <= 1'b0;
    end else begin
      lineDone <= 1'b0;
      lineError <= 1'b0;
      case (state)
        ST_INIT: state <= ST_COLLECT;
        ST_COLLECT: begin
          if (typeValid) begin
            kind <= recKind;
            wordIdx <= '0;
            overflow <= 1'b0;
            sum <= '0;
          end
          if (wordValid) begin
            sum <= sum + word;
            if (wordIdx < IDX_BITS'(BUF_WORDS + 2)) begin
              wordIdx <= wordIdx + 1'b1;
            end else begin
              overflow <= 1'b1;
            end
          end
          if (lineEnd) begin
            state <= ST_CHECK;
          end
        end
        ST_CHECK: begin
          state <= ST_COLLECT;
          if (isData && !endLine && lineGood && (dataCount != '0)) begin
            state <= ST_REPLAY;
            replayIdx <= '0;
            groupCnt <= '0;
            replayLast <= BUF_BITS'(dataCount - 1'b1);
          end else begin
            lineDone <= 1'b1;
            lineError <= (kind != KIND_IGNORED) && !(isData && (endLine || lineGood));
          end
          // End lines restart their kind at zero
          if (isData && (endLine || lineGood)) begin
            if (kind == KIND_CRAM) begin
              nextCram <= endLine ? '0 : baseAddr;
            end else begin
              nextDram <= endLine ? '0 : baseAddr;
            end
          end
        end
        ST_REPLAY: begin
          replayIdx <= replayIdx + 1'b1;
          groupCnt <= lastInGroup ? '0 : groupCnt + 1'b1;
          // One CRAM location or two DRAM entries per group
          if (lastInGroup && kind == KIND_CRAM) begin
            nextCram <= nextCram + 1'b1;
          end
          if (lastInGroup && kind == KIND_DRAM) begin
            nextDram <= nextDram + loadWordT'(2);
          end
          if (replayIdx == replayLast) begin
            state <= ST_DRAIN;
            // DRAM writes its odd entry one cycle later
            drainCnt <= (kind == KIND_DRAM);
          end
        end
        ST_DRAIN: begin
          if (drainCnt) begin
            drainCnt <= 1'b0;
          end else begin
            lineDone <= 1'b1;
            state <= ST_COLLECT;
          end
        end
        default: state <= ST_COLLECT;
      endcase
    end
  end

  // Decoder pulses land only while the parser collects
  decodeAccepted: assert property (@(posedge clk) disable iff (!arstN)
    (typeValid || wordValid || lineEnd) |-> wordReady)
    else $error("recordParser input while not ready");

endmodule
